// File: build.f
+incdir+design
+incdir+verification
design/hps_cmd_pkg.sv
design/video_pkg.sv
design/hps_cmd_decoder.sv
design/umuldiv.sv
design/aspect_window.sv
design/scaler_cfg_top.sv
verification/tb_scaler_cfg.sv

// File: design/aspect_window.sv
/*
 * Output window calculator
 * Clamps the scaled size to the output limits and centres it,
 * sequencing two multiply-divides through umuldiv
 */

`default_nettype none
`timescale 1ns/100ps

module aspect_window
	import video_pkg::*;
(
	input  wire     i_clk_sys,
	input  wire     i_resetd,

	input  dim_t    i_width,
	input  dim_t    i_height,
	input  dim_t    i_vset,
	input  dim_t    i_hset,
	input  wire     i_freescale,

	input  aspect_t i_arx,
	input  aspect_t i_ary,
	input  aspect_t i_arc1x,
	input  aspect_t i_arc1y,
	input  aspect_t i_arc2x,
	input  aspect_t i_arc2y,

	output dim_t    o_hmin,
	output dim_t    o_hmax,
	output dim_t    o_vmin,
	output dim_t    o_vmax
);

dim_t       hdmi_width;
dim_t       hdmi_height;
dim_t       sel_x;
dim_t       sel_y;
logic       sel_flag;
dim_t       calc_x;
dim_t       calc_y;
dim_t       wcalc;
dim_t       hcalc;
dim_t       videow;
dim_t       videoh;
dim_t       h_lo;
dim_t       v_lo;
win_state_t state;

logic       md_start;
logic       md_busy;
dim_t       md_mul1;
dim_t       md_mul2;
dim_t       md_div;
dim_t       md_result;

umuldiv u_muldiv (
	.i_clk_sys (i_clk_sys),
	.i_resetd  (i_resetd),
	.i_start   (md_start),
	.i_mul1    (md_mul1),
	.i_mul2    (md_mul2),
	.i_div     (md_div),
	.o_busy    (md_busy),
	.o_result  (md_result)
);

// Half of the unused border
assign h_lo = (i_width - videow) >> 1;
assign v_lo = (i_height - videoh) >> 1;

//////////////////////////////////////////////////
// Output limits and ratio select
//////////////////////////////////////////////////
always_ff @(posedge i_clk_sys) begin
	hdmi_width  <= (i_hset != 12'd0 && i_hset < i_width) ? i_hset : i_width;
	hdmi_height <= (i_vset != 12'd0 && i_vset < i_height) ? i_vset : i_height;

	if (i_ary == 13'd0) begin
		if (i_arx == 13'd1) begin
			sel_x    <= i_arc1x[11:0];
			sel_y    <= i_arc1y[11:0];
			sel_flag <= i_arc1x[12] | i_arc1y[12];
		end
		else if (i_arx == 13'd2) begin
			sel_x    <= i_arc2x[11:0];
			sel_y    <= i_arc2y[11:0];
			sel_flag <= i_arc2x[12] | i_arc2y[12];
		end
		else begin
			sel_x    <= '0;
			sel_y    <= '0;
			sel_flag <= 1'b0;
		end
	end
	else begin
		sel_x    <= i_arx[11:0];
		sel_y    <= i_ary[11:0];
		sel_flag <= i_arx[12] | i_ary[12];
	end
end

//////////////////////////////////////////////////
// Window FSM
//////////////////////////////////////////////////
always_ff @(posedge i_clk_sys) begin
	if (i_resetd) begin
		state    <= WIN_IDLE;
		md_start <= 1'b0;
		o_hmin   <= '0;
		o_hmax   <= '0;
		o_vmin   <= '0;
		o_vmax   <= '0;
	end
	else begin
		md_start <= 1'b0;
		case (state)
			WIN_IDLE: begin
				calc_x <= sel_x;
				calc_y <= sel_y;
				if (i_freescale || sel_x == 12'd0 || sel_y == 12'd0) begin
					wcalc <= hdmi_width;
					hcalc <= hdmi_height;
					state <= WIN_CLAMP;
				end
				else if (sel_flag) begin
					wcalc <= sel_x;
					hcalc <= sel_y;
					state <= WIN_CLAMP;
				end
				else
					state <= WIN_WMUL;
			end
			WIN_WMUL: begin
				md_mul1  <= hdmi_height;
				md_mul2  <= calc_x;
				md_div   <= calc_y;
				md_start <= 1'b1;
				state    <= WIN_WWAIT;
			end
			WIN_WWAIT: begin
				if (!md_start && !md_busy) begin
					wcalc <= md_result;
					state <= WIN_HMUL;
				end
			end
			WIN_HMUL: begin
				md_mul1  <= hdmi_width;
				md_mul2  <= calc_y;
				md_div   <= calc_x;
				md_start <= 1'b1;
				state    <= WIN_HWAIT;
			end
			WIN_HWAIT: begin
				if (!md_start && !md_busy) begin
					hcalc <= md_result;
					state <= WIN_CLAMP;
				end
			end
			WIN_CLAMP: begin
				videow <= (wcalc > hdmi_width) ? hdmi_width : wcalc;
				videoh <= (hcalc > hdmi_height) ? hdmi_height : hcalc;
				state  <= WIN_CENTRE;
			end
			WIN_CENTRE: begin
				o_hmin <= h_lo;
				o_hmax <= h_lo + videow - 12'd1;
				o_vmin <= v_lo;
				o_vmax <= v_lo + videoh - 12'd1;
				state  <= WIN_IDLE;
			end
			default: state <= WIN_IDLE;
		endcase
	end
end

// A non-empty window that fits the line gives an ordered range
a_h_order: assert property (@(posedge i_clk_sys) disable iff (i_resetd)
	(state == WIN_CENTRE && videow != 12'd0 && videow <= i_width) |=> o_hmax >= o_hmin);

endmodule

`default_nettype wire

// File: design/hps_cmd_decoder.sv
/*
 * Host command decoder
 * Frames strobed words into a command and its data,
 * holds timing size, window limits and custom aspect ratios
 */

`default_nettype none
`timescale 1ns/100ps

`include "video_defines.svh"

module hps_cmd_decoder
	import hps_cmd_pkg::*, video_pkg::*;
(
	input  wire      i_clk_sys,
	input  wire      i_resetd,

	input  wire      i_io_uio,
	input  wire      i_io_strobe,
	input  io_word_t i_io_din,

	output dim_t     o_width,
	output dim_t     o_height,
	output dim_t     o_vset,
	output dim_t     o_hset,
	output logic     o_freescale,
	output aspect_t  o_arc1x,
	output aspect_t  o_arc1y,
	output aspect_t  o_arc2x,
	output aspect_t  o_arc2y
);

logic      old_strobe;
logic      strobe_rise;
logic      has_cmd;
cmd_code_t cmd;
word_idx_t word_idx;

assign strobe_rise = i_io_strobe & ~old_strobe;

//////////////////////////////////////////////////
// Framing and register writes
//////////////////////////////////////////////////
always_ff @(posedge i_clk_sys) begin
	if (i_resetd) begin
		old_strobe  <= 1'b0;
		has_cmd     <= 1'b0;
		cmd         <= '0;
		word_idx    <= '0;
		o_width     <= `DEFAULT_WIDTH;
		o_height    <= `DEFAULT_HEIGHT;
		o_vset      <= '0;
		o_hset      <= '0;
		o_freescale <= 1'b0;
		o_arc1x     <= '0;
		o_arc1y     <= '0;
		o_arc2x     <= '0;
		o_arc2y     <= '0;
	end
	else begin
		old_strobe <= i_io_strobe;

		// Frame closed, forget the command
		if (!i_io_uio) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
		end
		else if (strobe_rise) begin
			if (!has_cmd) begin
				has_cmd  <= 1'b1;
				cmd      <= i_io_din[7:0];
				word_idx <= '0;
			end
			else begin
				// Saturate so long frames never wrap onto word 0
				if (word_idx != 4'hF)
					word_idx <= word_idx + 4'd1;

				case (cmd)
					`CMD_TIMING: begin
						// Other timing words are discarded
						if (word_idx == 4'd0)
							o_width <= i_io_din[11:0];
						if (word_idx == 4'd4)
							o_height <= i_io_din[11:0];
					end
					`CMD_VSET: begin
						o_vset <= i_io_din[11:0];
					end
					`CMD_HSET: begin
						o_freescale <= i_io_din[15];
						o_hset      <= i_io_din[11:0];
					end
					`CMD_ARC: begin
						case (word_idx)
							4'd0: o_arc1x <= i_io_din[12:0];
							4'd1: o_arc1y <= i_io_din[12:0];
							4'd2: o_arc2x <= i_io_din[12:0];
							4'd3: o_arc2y <= i_io_din[12:0];
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end
end

// Outside a frame the data counter must hold
a_idx_hold: assert property (@(posedge i_clk_sys) disable iff (i_resetd)
	!i_io_uio |=> word_idx == $past(word_idx));

endmodule

`default_nettype wire

// File: design/hps_cmd_pkg.sv
/*
 * Types of the host word port
 * and of the command decoder
 */

`default_nettype none

package hps_cmd_pkg;

	// One word from the host
	typedef logic [15:0] io_word_t;

	// Command code, low byte of the first word in a frame
	typedef logic [7:0] cmd_code_t;

	// Data word position after the command
	typedef logic [3:0] word_idx_t;

endpackage

`default_nettype wire

// File: design/scaler_cfg_top.sv
/*
 * Scaler configuration top level
 * Host command decoder feeding the window calculator
 */

`default_nettype none
`timescale 1ns/100ps

module scaler_cfg_top
	import hps_cmd_pkg::*, video_pkg::*;
(
	input  wire      i_clk_sys,
	input  wire      i_resetd,

	input  wire      i_io_uio,
	input  wire      i_io_strobe,
	input  io_word_t i_io_din,

	// Core aspect ratio
	input  aspect_t  i_arx,
	input  aspect_t  i_ary,

	output dim_t     o_hmin,
	output dim_t     o_hmax,
	output dim_t     o_vmin,
	output dim_t     o_vmax
);

dim_t    width;
dim_t    height;
dim_t    vset;
dim_t    hset;
logic    freescale;
aspect_t arc1x;
aspect_t arc1y;
aspect_t arc2x;
aspect_t arc2y;

hps_cmd_decoder u_decoder (
	.i_clk_sys   (i_clk_sys),
	.i_resetd    (i_resetd),
	.i_io_uio    (i_io_uio),
	.i_io_strobe (i_io_strobe),
	.i_io_din    (i_io_din),
	.o_width     (width),
	.o_height    (height),
	.o_vset      (vset),
	.o_hset      (hset),
	.o_freescale (freescale),
	.o_arc1x     (arc1x),
	.o_arc1y     (arc1y),
	.o_arc2x     (arc2x),
	.o_arc2y     (arc2y)
);

aspect_window u_window (
	.i_clk_sys   (i_clk_sys),
	.i_resetd    (i_resetd),
	.i_width     (width),
	.i_height    (height),
	.i_vset      (vset),
	.i_hset      (hset),
	.i_freescale (freescale),
	.i_arx       (i_arx),
	.i_ary       (i_ary),
	.i_arc1x     (arc1x),
	.i_arc1y     (arc1y),
	.i_arc2x     (arc2x),
	.i_arc2y     (arc2y),
	.o_hmin      (o_hmin),
	.o_hmax      (o_hmax),
	.o_vmin      (o_vmin),
	.o_vmax      (o_vmax)
);

endmodule

`default_nettype wire

// File: design/umuldiv.sv
/*
 * Serial unsigned multiply then divide
 * result = mul1 * mul2 / div, low 12 bits of the quotient
 */

`default_nettype none
`timescale 1ns/100ps

module umuldiv
	import video_pkg::*;
(
	input  wire  i_clk_sys,
	input  wire  i_resetd,
	input  wire  i_start,
	input  dim_t i_mul1,
	input  dim_t i_mul2,
	input  dim_t i_div,
	output logic o_busy,
	output dim_t o_result
);

logic        div_phase;
logic [4:0]  bit_cnt;
logic [23:0] acc;
logic [23:0] mcand;
logic [11:0] mplier;
dim_t        divisor;
logic [11:0] rem;
logic [23:0] partial;
logic [12:0] trial;
logic        q_bit;

// Two multiplier bits per step
assign partial = (mplier[0] ? mcand : 24'd0) + (mplier[1] ? {mcand[22:0], 1'b0} : 24'd0);

// Restoring division, product shifts out MSB first
assign trial = {rem, acc[23]};
assign q_bit = trial >= {1'b0, divisor};

always_ff @(posedge i_clk_sys) begin
	if (i_resetd) begin
		o_busy    <= 1'b0;
		div_phase <= 1'b0;
		bit_cnt   <= '0;
	end
	else if (i_start && !o_busy) begin
		o_busy    <= 1'b1;
		div_phase <= 1'b0;
	end
	else if (o_busy) begin
		if (!div_phase) begin
			// Stop early once no multiplier bits remain
			if (mplier[11:2] == 10'd0) begin
				div_phase <= 1'b1;
				bit_cnt   <= 5'd23;
			end
		end
		else begin
			bit_cnt <= bit_cnt - 5'd1;
			if (bit_cnt == 5'd0)
				o_busy <= 1'b0;
		end
	end
end

always_ff @(posedge i_clk_sys) begin
	if (i_start && !o_busy) begin
		acc     <= '0;
		mcand   <= {12'd0, i_mul1};
		mplier  <= i_mul2;
		divisor <= i_div;
	end
	else if (o_busy && !div_phase) begin
		acc    <= acc + partial;
		mcand  <= {mcand[21:0], 2'b00};
		mplier <= {2'b00, mplier[11:2]};
		rem    <= '0;
	end
	else if (o_busy) begin
		acc <= {acc[22:0], q_bit};
		rem <= q_bit ? (trial[11:0] - divisor) : trial[11:0];
		if (bit_cnt == 5'd0)
			o_result <= {acc[10:0], q_bit};
	end
end

a_start_ok: assert property (@(posedge i_clk_sys) disable iff (i_resetd)
	i_start |-> !o_busy && i_div != 12'd0);

endmodule

`default_nettype wire

// File: design/video_defines.svh
/*
 * Reset values of the video timing size
 * Command codes of the host configuration frames
 */

`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

//////////////////////////////////////////////////
// Default timing, 1920x1080 CEA
//////////////////////////////////////////////////
`define DEFAULT_WIDTH   12'd1920
`define DEFAULT_HEIGHT  12'd1080

//////////////////////////////////////////////////
// Host command codes
//////////////////////////////////////////////////
`define CMD_TIMING      8'h20
`define CMD_VSET        8'h27
`define CMD_HSET        8'h37
`define CMD_ARC         8'h3A

`endif

// File: design/video_pkg.sv
/*
 * Screen dimension and aspect types
 * States of the window calculator
 */

`default_nettype none

package video_pkg;

	// Pixel or line count
	typedef logic [11:0] dim_t;

	// Aspect value, bit 12 set means pixel sizes
	typedef logic [12:0] aspect_t;

	typedef enum logic [2:0] {
		WIN_IDLE,
		WIN_WMUL,
		WIN_WWAIT,
		WIN_HMUL,
		WIN_HWAIT,
		WIN_CLAMP,
		WIN_CENTRE
	} win_state_t;

endpackage

`default_nettype wire

// File: verification/tb_scaler_model.svh
/*
 * Reference model of the configuration registers and the window rule
 * Value compare task
 */

`ifndef TB_SCALER_MODEL_SVH
`define TB_SCALER_MODEL_SVH

// Mirror of the decoder registers
dim_t    m_width     = `DEFAULT_WIDTH;
dim_t    m_height    = `DEFAULT_HEIGHT;
dim_t    m_vset      = '0;
dim_t    m_hset      = '0;
logic    m_freescale = 1'b0;
aspect_t m_arc1x     = '0;
aspect_t m_arc1y     = '0;
aspect_t m_arc2x     = '0;
aspect_t m_arc2y     = '0;

task automatic model_write(input cmd_code_t cmd, input int idx, input io_word_t data);
	case (cmd)
		`CMD_TIMING: begin
			if (idx == 0)
				m_width = data[11:0];
			if (idx == 4)
				m_height = data[11:0];
		end
		`CMD_VSET: m_vset = data[11:0];
		`CMD_HSET: begin
			m_freescale = data[15];
			m_hset      = data[11:0];
		end
		`CMD_ARC: begin
			if (idx == 0) m_arc1x = data[12:0];
			if (idx == 1) m_arc1y = data[12:0];
			if (idx == 2) m_arc2x = data[12:0];
			if (idx == 3) m_arc2y = data[12:0];
		end
		default: ;
	endcase
endtask

//////////////////////////////////////////////////
// Window rule
//////////////////////////////////////////////////
task automatic model_window(input aspect_t arx, input aspect_t ary,
		output dim_t hmin, output dim_t hmax, output dim_t vmin, output dim_t vmax);
	dim_t        out_w;
	dim_t        out_h;
	aspect_t     rx;
	aspect_t     ry;
	dim_t        size_w;
	dim_t        size_h;
	logic [31:0] quot;
	out_w = (m_hset != 12'd0 && m_hset < m_width) ? m_hset : m_width;
	out_h = (m_vset != 12'd0 && m_vset < m_height) ? m_vset : m_height;
	rx = arx;
	ry = ary;
	if (ary == 13'd0) begin
		rx = (arx == 13'd1) ? m_arc1x : (arx == 13'd2) ? m_arc2x : 13'd0;
		ry = (arx == 13'd1) ? m_arc1y : (arx == 13'd2) ? m_arc2y : 13'd0;
	end
	if (m_freescale || rx[11:0] == 12'd0 || ry[11:0] == 12'd0) begin
		size_w = out_w;
		size_h = out_h;
	end
	else if (rx[12] | ry[12]) begin
		size_w = rx[11:0];
		size_h = ry[11:0];
	end
	else begin
		quot   = ({20'd0, out_h} * {20'd0, rx[11:0]}) / {20'd0, ry[11:0]};
		size_w = quot[11:0];
		quot   = ({20'd0, out_w} * {20'd0, ry[11:0]}) / {20'd0, rx[11:0]};
		size_h = quot[11:0];
	end
	if (size_w > out_w)
		size_w = out_w;
	if (size_h > out_h)
		size_h = out_h;
	hmin = (m_width - size_w) >> 1;
	hmax = hmin + size_w - 12'd1;
	vmin = (m_height - size_h) >> 1;
	vmax = vmin + size_h - 12'd1;
endtask

task automatic check_value(input string name, input dim_t got, input dim_t exp);
	if (got !== exp) begin
		$display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
		$display("Verification failed");
		$fatal(1);
	end
endtask

`endif

// File: verification/tb_scaler_cfg.sv
/*
 * Testbench of the scaler configuration path
 * Random host frames and core ratios, window checked against a model
 */

`default_nettype none
`timescale 1ns/100ps

`include "video_defines.svh"

module tb_scaler_cfg
	import hps_cmd_pkg::*, video_pkg::*;
();

localparam int CLK_PERIOD = 4;
localparam int N_TIMING   = 8;
localparam int N_LIMIT    = 10;
localparam int N_RATIO    = 12;
localparam int N_ARC      = 6;
localparam int N_FREE     = 4;
localparam int NUM_TESTS  = 1 + N_TIMING + N_LIMIT + N_RATIO + N_ARC + N_FREE + 3;
localparam int WATCHDOG_NS = NUM_TESTS * 400 * CLK_PERIOD + 2000;

logic     clk_sys;
logic     resetd;
logic     io_uio;
logic     io_strobe;
io_word_t io_din;
aspect_t  arx;
aspect_t  ary;
dim_t     hmin;
dim_t     hmax;
dim_t     vmin;
dim_t     vmax;
io_word_t frame_words [0:15];

`include "tb_scaler_model.svh"

scaler_cfg_top dut (
	.i_clk_sys   (clk_sys),
	.i_resetd    (resetd),
	.i_io_uio    (io_uio),
	.i_io_strobe (io_strobe),
	.i_io_din    (io_din),
	.i_arx       (arx),
	.i_ary       (ary),
	.o_hmin      (hmin),
	.o_hmax      (hmax),
	.o_vmin      (vmin),
	.o_vmax      (vmax)
);

always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

task automatic step_cycles(input int n);
	repeat (n) @(posedge clk_sys);
	#1;
endtask

function automatic dim_t random_dim(input int lo, input int span);
	logic [31:0] r;
	r = lo + $urandom % span;
	return r[11:0];
endfunction

function automatic aspect_t random_aspect();
	logic [31:0] pick;
	pick = $urandom;
	if (pick[0])
		return {1'b1, random_dim(100, 2400)};
	else
		return {1'b0, random_dim(1, 4095)};
endfunction

// Command word and n_words data words with the strobe toggling every 2 cycles
task automatic send_frame(input cmd_code_t cmd, input int n_words);
	int i;
	io_uio = 1'b1;
	io_din = {8'h00, cmd};
	step_cycles(2);
	io_strobe = 1'b1;
	step_cycles(2);
	io_strobe = 1'b0;
	step_cycles(2);
	for (i = 0; i < n_words; i++) begin
		io_din    = frame_words[i];
		io_strobe = 1'b1;
		step_cycles(2);
		io_strobe = 1'b0;
		step_cycles(2);
		model_write(cmd, i, frame_words[i]);
	end
	io_uio = 1'b0;
	step_cycles(2);
endtask

task automatic settle_and_check();
	dim_t e_hmin;
	dim_t e_hmax;
	dim_t e_vmin;
	dim_t e_vmax;
	step_cycles(200);
	model_window(arx, ary, e_hmin, e_hmax, e_vmin, e_vmax);
	check_value("o_hmin", hmin, e_hmin);
	check_value("o_hmax", hmax, e_hmax);
	check_value("o_vmin", vmin, e_vmin);
	check_value("o_vmax", vmax, e_vmax);
endtask

//////////////////////////////////////////////////
// Stimulus
//////////////////////////////////////////////////
initial begin
	logic [31:0] r32;
	int          k;
	int          i;
	void'($urandom(32'h6239));
	clk_sys   = 1'b0;
	resetd    = 1'b1;
	io_uio    = 1'b0;
	io_strobe = 1'b0;
	io_din    = '0;
	arx       = '0;
	ary       = '0;
	step_cycles(10);
	resetd = 1'b0;

	// Default 1920x1080 free window
	settle_and_check();
	check_value("o_hmax", hmax, 12'd1919);
	check_value("o_vmax", vmax, 12'd1079);

	for (k = 0; k < N_TIMING; k++) begin
		for (i = 0; i < 8; i++) begin
			r32 = $urandom;
			frame_words[i] = r32[15:0];
		end
		r32 = $urandom;
		frame_words[0] = {r32[3:0], random_dim(320, 1700)};
		frame_words[4] = {r32[7:4], random_dim(240, 1000)};
		send_frame(`CMD_TIMING, 8);
		settle_and_check();
	end

	for (k = 0; k < N_LIMIT; k++) begin
		frame_words[0] = {4'h0, random_dim(0, 2400)};
		send_frame(`CMD_VSET, 1);
		frame_words[0] = {4'h0, random_dim(0, 2400)};
		send_frame(`CMD_HSET, 1);
		settle_and_check();
	end

	for (k = 0; k < N_RATIO; k++) begin
		arx = {1'b0, random_dim(1, 4095)};
		ary = {1'b0, random_dim(1, 4095)};
		settle_and_check();
	end

	// Custom ratios through arx 1 and 2
	for (k = 0; k < N_ARC; k++) begin
		for (i = 0; i < 4; i++)
			frame_words[i] = {3'b000, random_aspect()};
		send_frame(`CMD_ARC, 4);
		arx = (k % 2 == 0) ? 13'd1 : 13'd2;
		ary = 13'd0;
		settle_and_check();
	end

	for (k = 0; k < N_FREE; k++) begin
		frame_words[0] = {4'h8, random_dim(0, 2400)};
		send_frame(`CMD_HSET, 1);
		arx = {1'b0, random_dim(1, 4095)};
		ary = {1'b0, random_dim(1, 4095)};
		settle_and_check();
	end

	// Frames closed early
	frame_words[0] = 16'h0000;
	send_frame(`CMD_HSET, 1);
	for (i = 0; i < 4; i++)
		frame_words[i] = {3'b000, random_aspect()};
	send_frame(`CMD_ARC, 2);
	arx = 13'd2;
	ary = 13'd0;
	settle_and_check();
	arx = 13'd1;
	settle_and_check();
	frame_words[0] = {4'h0, random_dim(320, 1700)};
	frame_words[4] = {4'h0, random_dim(240, 1000)};
	send_frame(`CMD_TIMING, 3);
	arx = 13'd0;
	settle_and_check();

	$display("Verification passed");
	$finish;
end

initial begin
	#(WATCHDOG_NS);
	$display("Timeout after %0d ns, the test sequence did not complete", WATCHDOG_NS);
	$display("Verification failed");
	$fatal(1);
end

endmodule

`default_nettype wire
